// ==== sc_pkg.sv ====
// sc_pkg: opcodes, widths, limits and state types shared by the serial command core
package sc_pkg;

	localparam int RAM_AW = 12; // 4096 samples per channel

	typedef logic [7:0] byte_t; // bus or uart byte
	typedef logic [RAM_AW-1:0] ram_addr_t; // sample ram address
	typedef logic [RAM_AW+1:0] send_cnt_t; // {channel, sample index}
	typedef logic [7:0] board_id_t;
	typedef logic [4:0] log2_t; // shift amount for skip and pacing
	typedef logic [63:0] chip_id_t; // unique fpga id

	// opcodes, groups of ten share one base
	localparam byte_t OP_ID_LAST = 8'd9; // 0..9 assign board id
	localparam byte_t OP_SEL_BASE = 8'd10; // 10..19 select board for readout
	localparam byte_t OP_LAST_BASE = 8'd20; // 20..29 mark last board
	localparam byte_t OP_ACT_BASE = 8'd30; // 30..39 make board active
	localparam byte_t OP_PRIME = 8'd100; // arm the trigger
	localparam byte_t OP_ROLL_ON = 8'd101;
	localparam byte_t OP_ROLL_OFF = 8'd102;
	localparam byte_t OP_TRIGPT = 8'd121; // 2 arg bytes
	localparam byte_t OP_NSEND = 8'd122; // 2 arg bytes
	localparam byte_t OP_SKIP = 8'd123; // 1 arg byte
	localparam byte_t OP_PACE = 8'd125; // 1 arg byte
	localparam byte_t OP_REARM = 8'd139; // toggle automatic rearm
	localparam byte_t OP_CHIPID = 8'd142; // send 64-bit id

	localparam board_id_t ID_RESET = 8'd200; // not yet enumerated

	// trigger point window inside the ram
	localparam int TP_MIN = 4;
	localparam int TP_MAX = (1 << RAM_AW) - 16;

	// log2 of cycles between uart bytes
	localparam int PACE_MAX = 30;
	localparam int PACE_MIN = 1; // keeps at least 2 cycles of ram settling

	localparam int WAIT_TIMEOUT = 2000; // cycles to wait for a capture
	localparam int N_CHAN = 4;
	localparam int CHIP_ID_BYTES = 8;

	// argument bytes that follow an opcode
	function automatic logic [1:0] arg_count(byte_t op);
		case (op)
			OP_TRIGPT, OP_NSEND: arg_count = 2'd2;
			OP_SKIP, OP_PACE: arg_count = 2'd1;
			default: arg_count = 2'd0;
		endcase
	endfunction

	typedef enum logic {
		RD_RAM, // four channels from sample ram
		RD_CHIPID
	} rd_mode_e;

	typedef enum logic {
		COL_IDLE,
		COL_GATHER
	} collector_state_e;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_WAIT, // selected, waiting for capture
		CTRL_RUN // readout in progress
	} ctrl_state_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SETTLE, // pacing gap, ram address stable
		SEQ_SEND
	} seq_state_e;

endpackage

// ==== cmd_if.sv ====
// cmd_if: parsed opcode and argument events from the byte collector to the controller
`timescale 1ns/1ps
interface cmd_if;
	import sc_pkg::*;

	logic op_valid; // one cycle, with opcode
	byte_t opcode;
	logic arg_valid; // one cycle per argument byte
	byte_t arg_byte;
	logic args_done; // last argument in
	logic [15:0] args; // first byte in the high half

	modport collector (
		output op_valid, opcode, arg_valid, arg_byte, args_done, args
	);

	modport ctrl (
		input op_valid, opcode, arg_valid, arg_byte, args_done, args
	);

endinterface

// ==== readout_if.sv ====
// readout_if: readout request and held settings from the controller to the sequencer
`timescale 1ns/1ps
interface readout_if;
	import sc_pkg::*;

	logic start; // one cycle, with mode
	rd_mode_e mode;
	ram_addr_t trig_point; // samples before the trigger
	ram_addr_t n_send; // samples per channel, 0 means whole ram
	log2_t skip_log2;
	log2_t pace_log2;
	logic busy; // level while streaming
	logic done; // one cycle at the end

	modport ctrl (
		output start, mode, trig_point, n_send, skip_log2, pace_log2,
		input busy, done
	);

	modport seq (
		input start, mode, trig_point, n_send, skip_log2, pace_log2,
		output busy, done
	);

endinterface

// ==== cmd_collector.sv ====
// cmd_collector: turns received uart bytes into opcode, argument and done events
`timescale 1ns/1ps
module cmd_collector (
	input logic clk,
	input logic rst_n,
	input logic rx_ready,
	input sc_pkg::byte_t rx_data,
	cmd_if.collector cmd
);
	import sc_pkg::*;

	collector_state_e state;
	logic [1:0] remaining; // argument bytes still expected
	logic take_op; // byte is an opcode
	logic take_arg; // byte is an argument

	assign take_op = (state == COL_IDLE) && rx_ready;
	assign take_arg = (state == COL_GATHER) && rx_ready && (remaining != 2'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= COL_IDLE;
			remaining <= 2'd0;
			cmd.op_valid <= 1'b0;
			cmd.arg_valid <= 1'b0;
			cmd.args_done <= 1'b0;
		end else begin
			cmd.op_valid <= 1'b0; // strobes last one cycle
			cmd.arg_valid <= 1'b0;
			cmd.args_done <= 1'b0;
			case (state)
				COL_IDLE: begin
					if (take_op) begin
						cmd.op_valid <= 1'b1;
						remaining <= arg_count(rx_data); // unknown ops count as 0
						state <= COL_GATHER;
					end
				end
				COL_GATHER: begin
					if (remaining == 2'd0) begin
						// bare opcode, done right after the op strobe
						cmd.args_done <= 1'b1;
						state <= COL_IDLE;
					end else if (take_arg) begin
						cmd.arg_valid <= 1'b1;
						remaining <= remaining - 2'd1;
						if (remaining == 2'd1) begin
							cmd.args_done <= 1'b1; // together with last arg
							state <= COL_IDLE;
						end
					end
				end
				default: state <= COL_IDLE;
			endcase
		end
	end

	// opcode and argument bytes
	always_ff @(posedge clk) begin
		if (take_op) begin
			cmd.opcode <= rx_data;
			cmd.args <= '0;
		end else if (take_arg) begin
			cmd.arg_byte <= rx_data;
			cmd.args <= {cmd.args[7:0], rx_data}; // shift in, first byte ends high
		end
	end

	// an opcode byte is never also an argument byte
	assert property (@(posedge clk) disable iff (!rst_n)
		!(cmd.op_valid && cmd.arg_valid))
		else $error("opcode and argument strobes overlap");

endmodule

// ==== chain_ctrl.sv ====
// chain_ctrl: board id, chain role, config registers, forwarding and readout launch
`timescale 1ns/1ps
module chain_ctrl (
	input logic clk,
	input logic rst_n,
	cmd_if.ctrl cmd,
	readout_if.ctrl rd,
	input logic ext_data_ready,
	output logic com_new,
	output sc_pkg::byte_t com_data,
	output logic serial_passthrough,
	output logic [1:0] master_clock,
	output logic im_the_last,
	output logic im_the_first,
	output logic rolling_trigger,
	output logic get_ext_data
);
	import sc_pkg::*;

	localparam int WAIT_W = $clog2(WAIT_TIMEOUT + 1);

	ctrl_state_e state;
	board_id_t my_id;
	byte_t pend_op; // opcode waiting for its arguments
	logic autorearm;
	logic [WAIT_W-1:0] wait_cnt;

	// opcode decode
	logic is_id, is_sel, is_last, is_act, known;
	byte_t grp_id; // board addressed by a grouped opcode
	logic for_me;
	// argument decode
	ram_addr_t ns_arg;
	ram_addr_t tp_clamped;
	log2_t pace_clamped;
	log2_t skip_clamped;
	logic tp_too_late; // trigger point past n_send-5

	always_comb begin
		is_id = cmd.opcode <= OP_ID_LAST;
		is_sel = (cmd.opcode >= OP_SEL_BASE) && (cmd.opcode < OP_LAST_BASE);
		is_last = (cmd.opcode >= OP_LAST_BASE) && (cmd.opcode < OP_ACT_BASE);
		is_act = (cmd.opcode >= OP_ACT_BASE) && (cmd.opcode < OP_ACT_BASE + 8'd10);
		if (is_sel)
			grp_id = cmd.opcode - OP_SEL_BASE;
		else if (is_last)
			grp_id = cmd.opcode - OP_LAST_BASE;
		else
			grp_id = cmd.opcode - OP_ACT_BASE;
		for_me = grp_id == my_id;
		known = is_sel || is_last || is_act || (arg_count(cmd.opcode) != 2'd0)
			|| cmd.opcode == OP_PRIME || cmd.opcode == OP_ROLL_ON
			|| cmd.opcode == OP_ROLL_OFF || cmd.opcode == OP_REARM
			|| cmd.opcode == OP_CHIPID;

		ns_arg = cmd.args[RAM_AW-1:0];
		tp_too_late = ({1'b0, rd.trig_point} + (RAM_AW+1)'(5)) > {1'b0, ns_arg};
		if (cmd.args > 16'(TP_MAX))
			tp_clamped = ram_addr_t'(TP_MAX);
		else if (cmd.args < 16'(TP_MIN))
			tp_clamped = ram_addr_t'(TP_MIN);
		else
			tp_clamped = cmd.args[RAM_AW-1:0];
		if (cmd.args[7:0] > 8'(PACE_MAX))
			pace_clamped = log2_t'(PACE_MAX);
		else if (cmd.args[7:0] < 8'(PACE_MIN))
			pace_clamped = log2_t'(PACE_MIN);
		else
			pace_clamped = cmd.args[4:0];
		// a step as large as the ram would never advance the sample index
		if (cmd.args[7:0] >= 8'(RAM_AW))
			skip_clamped = log2_t'(RAM_AW - 1);
		else
			skip_clamped = cmd.args[4:0];
	end

	assign im_the_first = my_id == 8'd0; // head of the chain

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= CTRL_IDLE;
			my_id <= ID_RESET;
			pend_op <= '0;
			autorearm <= 1'b0;
			wait_cnt <= '0;
			com_new <= 1'b0;
			com_data <= '0;
			serial_passthrough <= 1'b0;
			master_clock <= 2'b00; // own clock master
			im_the_last <= 1'b0;
			rolling_trigger <= 1'b1;
			get_ext_data <= 1'b0;
			rd.start <= 1'b0;
			rd.mode <= RD_RAM;
			rd.trig_point <= ram_addr_t'(1 << (RAM_AW - 2)); // quarter of the ram
			rd.n_send <= '0;
			rd.skip_log2 <= '0;
			rd.pace_log2 <= log2_t'(5);
		end else begin
			com_new <= 1'b0;
			get_ext_data <= 1'b0;
			rd.start <= 1'b0;

			if (cmd.arg_valid) begin // args always go down the chain
				com_new <= 1'b1;
				com_data <= cmd.arg_byte;
			end

			if (cmd.args_done) begin
				case (pend_op)
					OP_TRIGPT: rd.trig_point <= tp_clamped;
					OP_NSEND: begin
						rd.n_send <= ns_arg;
						if (tp_too_late)
							rd.trig_point <= ns_arg >> 1; // keep trigger inside window
					end
					OP_SKIP: rd.skip_log2 <= skip_clamped;
					OP_PACE: rd.pace_log2 <= pace_clamped;
					default: ;
				endcase
			end

			if (cmd.op_valid)
				pend_op <= '0; // dropped unless accepted below

			case (state)
				CTRL_IDLE: begin
					if (cmd.op_valid && !rd.busy) begin
						pend_op <= cmd.opcode;
						if (is_id) begin
							my_id <= cmd.opcode;
							master_clock <= (cmd.opcode == 8'd0) ? 2'b00 : 2'b01;
							com_data <= cmd.opcode + 8'd1; // next board gets id+1
							com_new <= 1'b1;
						end else if (is_sel && for_me) begin
							serial_passthrough <= 1'b0;
							wait_cnt <= '0;
							state <= CTRL_WAIT;
						end else if (cmd.opcode == OP_CHIPID && !serial_passthrough) begin
							rd.mode <= RD_CHIPID;
							rd.start <= 1'b1;
							state <= CTRL_RUN;
						end else if (known) begin
							com_data <= cmd.opcode;
							com_new <= 1'b1;
							if (is_sel)
								serial_passthrough <= 1'b1; // another board talks
							if (is_last)
								im_the_last <= for_me;
							if (is_act)
								serial_passthrough <= !for_me;
							if (cmd.opcode == OP_PRIME)
								get_ext_data <= 1'b1;
							if (cmd.opcode == OP_ROLL_ON)
								rolling_trigger <= 1'b1;
							if (cmd.opcode == OP_ROLL_OFF)
								rolling_trigger <= 1'b0;
							if (cmd.opcode == OP_REARM)
								autorearm <= !autorearm;
						end
					end
				end
				CTRL_WAIT: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (ext_data_ready) begin
						rd.mode <= RD_RAM;
						rd.start <= 1'b1;
						state <= CTRL_RUN;
					end else if (wait_cnt == WAIT_W'(WAIT_TIMEOUT)) begin
						state <= CTRL_IDLE; // no capture, give up
					end
				end
				CTRL_RUN: begin
					if (rd.done) begin
						state <= CTRL_IDLE;
						if (autorearm && rd.mode == RD_RAM)
							get_ext_data <= 1'b1; // arm for the next capture
					end
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// a readout is only requested while the sequencer is free
	assert property (@(posedge clk) disable iff (!rst_n) rd.start |-> !rd.busy)
		else $error("readout start while sequencer busy");

endmodule

// ==== readout_seq.sv ====
// readout_seq: paces uart bytes out of the sample ram or the chip id
`timescale 1ns/1ps
module readout_seq (
	input logic clk,
	input logic rst_n,
	readout_if.seq rd,
	input logic tx_busy,
	output logic tx_start,
	output sc_pkg::byte_t tx_data,
	output logic rden,
	output sc_pkg::ram_addr_t rdaddress,
	input sc_pkg::ram_addr_t wraddress_triggerpoint,
	input sc_pkg::byte_t ram_out0,
	input sc_pkg::byte_t ram_out1,
	input sc_pkg::byte_t ram_out2,
	input sc_pkg::byte_t ram_out3,
	input sc_pkg::chip_id_t chip_id
);
	import sc_pkg::*;

	seq_state_e state;
	send_cnt_t cnt; // {channel, sample index}
	ram_addr_t start_addr; // first sample of each channel
	logic [2:0] id_idx; // chip id byte, lsb first
	logic [PACE_MAX:0] pace_cnt; // settle counter, bit pace_log2 ends the gap

	byte_t ram_byte; // current channel's ram output
	send_cnt_t step;
	send_cnt_t cnt_nxt;
	logic chan_wrap; // index done, go to next channel
	logic last_byte;
	logic send_now;

	always_comb begin
		case (cnt[RAM_AW+1:RAM_AW])
			2'd0: ram_byte = ram_out0;
			2'd1: ram_byte = ram_out1;
			2'd2: ram_byte = ram_out2;
			default: ram_byte = ram_out3;
		endcase
		step = send_cnt_t'(1) << rd.skip_log2;
		cnt_nxt = cnt + step;
		// carry into the channel bits also ends the channel
		chan_wrap = (cnt_nxt[RAM_AW+1:RAM_AW] != cnt[RAM_AW+1:RAM_AW])
			|| (rd.n_send != '0 && cnt_nxt[RAM_AW-1:0] >= rd.n_send);
		if (rd.mode == RD_CHIPID)
			last_byte = id_idx == 3'(CHIP_ID_BYTES - 1);
		else
			last_byte = chan_wrap && (cnt[RAM_AW+1:RAM_AW] == 2'(N_CHAN - 1));
	end

	assign send_now = (state == SEQ_SEND) && !tx_busy; // uart free, byte goes out

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			cnt <= '0;
			id_idx <= '0;
			pace_cnt <= '0;
			tx_start <= 1'b0;
			rden <= 1'b0;
			rd.busy <= 1'b0;
			rd.done <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			rd.done <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (rd.start) begin
						rd.busy <= 1'b1;
						cnt <= '0;
						id_idx <= '0;
						pace_cnt <= '0;
						rden <= rd.mode == RD_RAM;
						state <= SEQ_SETTLE;
					end
				end
				SEQ_SETTLE: begin
					pace_cnt <= pace_cnt + 1'b1;
					if (pace_cnt[rd.pace_log2])
						state <= SEQ_SEND; // address held 2^pace cycles
				end
				SEQ_SEND: begin
					if (send_now) begin
						tx_start <= 1'b1;
						pace_cnt <= '0;
						if (rd.mode == RD_CHIPID)
							id_idx <= id_idx + 3'd1;
						else if (chan_wrap)
							cnt <= {cnt[RAM_AW+1:RAM_AW] + 2'd1, ram_addr_t'(0)};
						else
							cnt <= cnt_nxt;
						if (last_byte) begin
							rd.busy <= 1'b0;
							rd.done <= 1'b1;
							rden <= 1'b0;
							state <= SEQ_IDLE;
						end else begin
							state <= SEQ_SETTLE;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// byte and address path
	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && rd.start) begin
			start_addr <= wraddress_triggerpoint - rd.trig_point; // back from trigger
			rdaddress <= wraddress_triggerpoint - rd.trig_point;
		end else if (send_now) begin
			if (rd.mode == RD_CHIPID)
				tx_data <= chip_id[8*id_idx +: 8];
			else
				tx_data <= ram_byte; // sampled after the settle gap
			if (rd.mode == RD_RAM)
				rdaddress <= chan_wrap ? start_addr : rdaddress + step[RAM_AW-1:0];
		end
	end

	// back-pressure from the uart is respected
	assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
		else $error("tx_start while uart busy");

endmodule

// ==== scope_chain_top.sv ====
// scope_chain_top: serial command core of one daisy-chained scope board
`timescale 1ns/1ps
module scope_chain_top (
	input logic clk,
	input logic rst_n,
	// uart receive
	input logic rx_ready,
	input sc_pkg::byte_t rx_data,
	// uart transmit
	input logic tx_busy,
	output logic tx_start,
	output sc_pkg::byte_t tx_data,
	// chain
	output logic com_new,
	output sc_pkg::byte_t com_data,
	output logic serial_passthrough,
	output logic [1:0] master_clock,
	output logic im_the_last,
	output logic im_the_first,
	output logic rolling_trigger,
	output logic get_ext_data,
	// capture and sample ram
	input logic ext_data_ready,
	input sc_pkg::ram_addr_t wraddress_triggerpoint,
	output logic rden,
	output sc_pkg::ram_addr_t rdaddress,
	input sc_pkg::byte_t ram_out0,
	input sc_pkg::byte_t ram_out1,
	input sc_pkg::byte_t ram_out2,
	input sc_pkg::byte_t ram_out3,
	input sc_pkg::chip_id_t chip_id
);

	cmd_if cmd_bus ();
	readout_if rd_bus ();

	cmd_collector u_collector (
		.clk (clk),
		.rst_n (rst_n),
		.rx_ready (rx_ready),
		.rx_data (rx_data),
		.cmd (cmd_bus.collector)
	);

	chain_ctrl u_ctrl (
		.clk (clk),
		.rst_n (rst_n),
		.cmd (cmd_bus.ctrl),
		.rd (rd_bus.ctrl),
		.ext_data_ready (ext_data_ready),
		.com_new (com_new),
		.com_data (com_data),
		.serial_passthrough (serial_passthrough),
		.master_clock (master_clock),
		.im_the_last (im_the_last),
		.im_the_first (im_the_first),
		.rolling_trigger (rolling_trigger),
		.get_ext_data (get_ext_data)
	);

	readout_seq u_seq (
		.clk (clk),
		.rst_n (rst_n),
		.rd (rd_bus.seq),
		.tx_busy (tx_busy),
		.tx_start (tx_start),
		.tx_data (tx_data),
		.rden (rden),
		.rdaddress (rdaddress),
		.wraddress_triggerpoint (wraddress_triggerpoint),
		.ram_out0 (ram_out0),
		.ram_out1 (ram_out1),
		.ram_out2 (ram_out2),
		.ram_out3 (ram_out3),
		.chip_id (chip_id)
	);

endmodule

// ==== tb_scope_chain.sv ====
// tb_scope_chain: table-driven testbench for the scope chain command core with uart and ram models
`timescale 1ns/1ps
module tb_scope_chain;
	import sc_pkg::*;

	localparam int N_TESTS = 20;
	// one 2000-cycle select timeout, two 32-byte readouts near 400 cycles each,
	// two 8-byte id readouts under 300 cycles each, short entries, wide margin
	localparam int CYCLE_LIMIT = 20000;
	localparam logic [1:0] TX_NONE = 2'd0;
	localparam logic [1:0] TX_CHIPID = 2'd1;
	localparam logic [1:0] TX_RAM = 2'd2;
	localparam ram_addr_t WTP = 12'h5a3; // write pointer at the trigger
	localparam chip_id_t CHIP_ID = 64'hf00d_c0de_1234_5a69;
	localparam int NSEND_SET = 8; // from 122 with 0,8
	localparam int TP_SET = TP_MIN; // 121 with 0,2 clamps up

	typedef struct packed {
		logic do_reset; // fresh reset before the bytes
		logic [1:0] n_cmd;
		logic [23:0] cmd; // first byte high
		logic [1:0] n_fwd;
		logic [23:0] fwd; // expected com_data bytes, first high
		logic use_ext; // raise ext_data_ready after a random delay
		logic hold; // select left waiting for a capture that never comes
		logic [1:0] tx_kind;
		logic [5:0] lvl; // {passthrough, master_clock, last, first, rolling}
		logic [1:0] n_gext; // get_ext_data pulses
	} test_t;

	logic clk = 1'b0;
	logic rst_n, rx_ready, tx_busy, tx_start, com_new;
	byte_t rx_data, tx_data, com_data;
	logic serial_passthrough, im_the_last, im_the_first, rolling_trigger;
	logic [1:0] master_clock;
	logic get_ext_data, ext_data_ready, rden;
	ram_addr_t wraddress_triggerpoint, rdaddress;
	byte_t ram_out0, ram_out1, ram_out2, ram_out3;
	chip_id_t chip_id;

	test_t tests [0:N_TESTS-1];
	byte_t fwd_q[$]; // seen on com_data
	byte_t tx_q[$]; // seen on tx_data
	byte_t exp_tx[$];
	int gext_cnt = 0;
	int cycle_cnt = 0;
	int busy_left = 0; // uart model busy cycles
	int errors = 0;
	int checks = 0;
	int seed;

	scope_chain_top uut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// monitors, sampled on the edge so strobes are read before they change
	always @(posedge clk) begin
		if (com_new)
			fwd_q.push_back(com_data);
		if (tx_start)
			tx_q.push_back(tx_data);
		if (get_ext_data)
			gext_cnt++;
	end

	// uart transmitter, busy for 6 cycles after each start
	always @(posedge clk) begin
		if (tx_start)
			busy_left = 6;
		else if (busy_left != 0)
			busy_left = busy_left - 1;
		tx_busy <= #1 (busy_left != 0);
	end

	// low address byte with the page folded in, channel in bits 7:6
	function automatic byte_t ram_pattern(input logic [1:0] chan, input ram_addr_t addr);
		ram_pattern = addr[7:0] ^ {4'h0, addr[11:8]} ^ {chan, 6'b0};
	endfunction

	always @(posedge clk) begin // registered ram, one cycle latency
		if (rden) begin
			ram_out0 <= #1 ram_pattern(2'd0, rdaddress);
			ram_out1 <= #1 ram_pattern(2'd1, rdaddress);
			ram_out2 <= #1 ram_pattern(2'd2, rdaddress);
			ram_out3 <= #1 ram_pattern(2'd3, rdaddress);
		end
	end

	function automatic logic [23:0] bytes3(input byte_t a, input byte_t b, input byte_t c);
		bytes3 = {a, b, c};
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s = %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		wait_cycles(2);
		rst_n = 1'b1;
	endtask

	task automatic send_byte(input byte_t b); // one rx strobe, then a gap for args_done
		rx_data = b;
		rx_ready = 1'b1;
		wait_cycles(1);
		rx_ready = 1'b0;
		wait_cycles(2);
	endtask

	task automatic expect_tx(input logic [1:0] kind);
		ram_addr_t a;
		exp_tx.delete();
		if (kind == TX_CHIPID) begin
			for (int k = 0; k < CHIP_ID_BYTES; k++)
				exp_tx.push_back(CHIP_ID[8*k +: 8]); // lsb first
		end else if (kind == TX_RAM) begin
			for (int c = 0; c < N_CHAN; c++) begin
				for (int i = 0; i < NSEND_SET; i++) begin
					a = WTP - ram_addr_t'(TP_SET) + ram_addr_t'(i);
					exp_tx.push_back(ram_pattern(c[1:0], a));
				end
			end
		end
	endtask

	task automatic run_test(input int idx);
		test_t tc;
		int err_before;
		tc = tests[idx];
		err_before = errors;
		if (tc.do_reset)
			apply_reset();
		fwd_q.delete();
		tx_q.delete();
		gext_cnt = 0;
		expect_tx(tc.tx_kind);
		for (int k = 0; k < tc.n_cmd; k++)
			send_byte(tc.cmd[23 - 8*k -: 8]);
		if (tc.use_ext) begin
			wait_cycles(2 + ($random(seed) & 15)); // capture finishes later
			ext_data_ready = 1'b1;
		end
		if (tc.hold)
			wait_cycles(WAIT_TIMEOUT + 10); // let the select give up
		while (tx_q.size() < exp_tx.size())
			@(posedge clk);
		wait_cycles(10); // trailing strobes land
		ext_data_ready = 1'b0;
		check_value("forwarded byte count", fwd_q.size(), tc.n_fwd);
		for (int k = 0; k < tc.n_fwd && k < fwd_q.size(); k++)
			check_value("com_data", fwd_q[k], tc.fwd[23 - 8*k -: 8]);
		check_value("tx byte count", tx_q.size(), exp_tx.size());
		for (int k = 0; k < exp_tx.size() && k < tx_q.size(); k++)
			check_value("tx_data", tx_q[k], exp_tx[k]);
		check_value("serial_passthrough", serial_passthrough, tc.lvl[5]);
		check_value("master_clock", master_clock, tc.lvl[4:3]);
		check_value("im_the_last", im_the_last, tc.lvl[2]);
		check_value("im_the_first", im_the_first, tc.lvl[1]);
		check_value("rolling_trigger", rolling_trigger, tc.lvl[0]);
		check_value("rden", rden, 1'b0); // ram read off once the readout is over
		check_value("get_ext_data pulses", gext_cnt, tc.n_gext);
		$display("test %0d, first byte %0d: %s", idx, tc.cmd[23:16],
			(errors == err_before) ? "ok" : "failed");
	endtask

	initial begin
		seed = 11041;
		rst_n = 1'b0;
		rx_ready = 1'b0;
		rx_data = '0;
		tx_busy = 1'b0;
		ext_data_ready = 1'b0;
		wraddress_triggerpoint = WTP;
		chip_id = CHIP_ID;
		{ram_out0, ram_out1, ram_out2, ram_out3} = '0;
		// id assignment and last board
		tests[0] = {1'b1, 2'd1, bytes3(0, 0, 0), 2'd1, bytes3(1, 0, 0), 2'b00, TX_NONE,
			6'b0_00_0_1_1, 2'd0};
		tests[1] = {1'b0, 2'd1, bytes3(3, 0, 0), 2'd1, bytes3(4, 0, 0), 2'b00, TX_NONE,
			6'b0_01_0_0_1, 2'd0};
		tests[2] = {1'b0, 2'd1, bytes3(23, 0, 0), 2'd1, bytes3(23, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		// another board selected, id request passes through, unknown dropped
		tests[3] = {1'b0, 2'd1, bytes3(12, 0, 0), 2'd1, bytes3(12, 0, 0), 2'b00, TX_NONE,
			6'b1_01_1_0_1, 2'd0};
		tests[4] = {1'b0, 2'd1, bytes3(142, 0, 0), 2'd1, bytes3(142, 0, 0), 2'b00, TX_NONE,
			6'b1_01_1_0_1, 2'd0};
		tests[5] = {1'b0, 2'd1, bytes3(90, 0, 0), 2'd0, 24'd0, 2'b00, TX_NONE,
			6'b1_01_1_0_1, 2'd0};
		// activate, then chip id out
		tests[6] = {1'b0, 2'd1, bytes3(33, 0, 0), 2'd1, bytes3(33, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[7] = {1'b0, 2'd1, bytes3(142, 0, 0), 2'd0, 24'd0, 2'b00, TX_CHIPID,
			6'b0_01_1_0_1, 2'd0};
		// config with arguments
		tests[8] = {1'b0, 2'd3, bytes3(122, 0, 8), 2'd3, bytes3(122, 0, 8), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[9] = {1'b0, 2'd3, bytes3(121, 0, 2), 2'd3, bytes3(121, 0, 2), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[10] = {1'b0, 2'd2, bytes3(123, 0, 0), 2'd2, bytes3(123, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[11] = {1'b0, 2'd2, bytes3(125, 2, 0), 2'd2, bytes3(125, 2, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[12] = {1'b0, 2'd1, bytes3(13, 0, 0), 2'd0, 24'd0, 2'b10, TX_RAM,
			6'b0_01_1_0_1, 2'd0};
		// trigger control and autorearm
		tests[13] = {1'b0, 2'd1, bytes3(100, 0, 0), 2'd1, bytes3(100, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd1};
		tests[14] = {1'b0, 2'd1, bytes3(102, 0, 0), 2'd1, bytes3(102, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_0, 2'd0};
		tests[15] = {1'b0, 2'd1, bytes3(101, 0, 0), 2'd1, bytes3(101, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[16] = {1'b0, 2'd1, bytes3(139, 0, 0), 2'd1, bytes3(139, 0, 0), 2'b00, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[17] = {1'b0, 2'd1, bytes3(13, 0, 0), 2'd0, 24'd0, 2'b10, TX_RAM,
			6'b0_01_1_0_1, 2'd1};
		// select with no capture times out, id still served afterwards
		tests[18] = {1'b0, 2'd1, bytes3(13, 0, 0), 2'd0, 24'd0, 2'b01, TX_NONE,
			6'b0_01_1_0_1, 2'd0};
		tests[19] = {1'b0, 2'd1, bytes3(142, 0, 0), 2'd0, 24'd0, 2'b00, TX_CHIPID,
			6'b0_01_1_0_1, 2'd0};
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== flist.f ====
sc_pkg.sv
cmd_if.sv
readout_if.sv
cmd_collector.sv
chain_ctrl.sv
readout_seq.sv
scope_chain_top.sv
tb_scope_chain.sv

// ==== Bender.yml ====
package:
  name: scope_chain

sources:
  - sc_pkg.sv
  - cmd_if.sv
  - readout_if.sv
  - cmd_collector.sv
  - chain_ctrl.sv
  - readout_seq.sv
  - scope_chain_top.sv
  - target: simulation
    files:
      - tb_scope_chain.sv
